// ==== adam_axil_apb_bridge.sv ====
`timescale 1ns/1ps

module adam_axil_apb_bridge import adam_bridge_pkg::*; (
    input  logic clk,
    input  logic reset,

    input  logic pause_req,
    output logic pause_ack,

    // AXI-Lite slave
    input  addr_t aw_addr,
    input  prot_t aw_prot,
    input  logic  aw_valid,
    output logic  aw_ready,
    input  data_t w_data,
    input  strb_t w_strb,
    input  logic  w_valid,
    output logic  w_ready,
    output resp_t b_resp,
    output logic  b_valid,
    input  logic  b_ready,
    input  addr_t ar_addr,
    input  prot_t ar_prot,
    input  logic  ar_valid,
    output logic  ar_ready,
    output data_t r_data,
    output resp_t r_resp,
    output logic  r_valid,
    input  logic  r_ready,

    // APB masters
    output addr_t [NO_APBS-1:0] paddr,
    output prot_t [NO_APBS-1:0] pprot,
    output logic  [NO_APBS-1:0] psel,
    output logic  [NO_APBS-1:0] penable,
    output logic  [NO_APBS-1:0] pwrite,
    output data_t [NO_APBS-1:0] pwdata,
    output strb_t [NO_APBS-1:0] pstrb,
    input  logic  [NO_APBS-1:0] pready,
    input  data_t [NO_APBS-1:0] prdata,
    input  logic  [NO_APBS-1:0] pslverr,

    input  addr_t [NO_APBS-1:0] map_start, // Rule covers start up to end exclusive
    input  addr_t [NO_APBS-1:0] map_end
);

    logic  fsm_aw_valid;
    logic  fsm_aw_ready;
    logic  fsm_w_valid;
    logic  fsm_w_ready;
    logic  fsm_ar_valid;
    logic  fsm_ar_ready;
    logic  b_push;
    resp_t b_push_resp;
    logic  b_full;
    logic  r_push;
    data_t r_push_data;
    resp_t r_push_resp;
    logic  r_full;

    adam_axil_pause u_pause (
        .clk          (clk),
        .reset        (reset),
        .pause_req    (pause_req),
        .pause_ack    (pause_ack),
        .aw_valid     (aw_valid),
        .aw_ready     (aw_ready),
        .w_valid      (w_valid),
        .w_ready      (w_ready),
        .ar_valid     (ar_valid),
        .ar_ready     (ar_ready),
        .fsm_aw_valid (fsm_aw_valid),
        .fsm_aw_ready (fsm_aw_ready),
        .fsm_w_valid  (fsm_w_valid),
        .fsm_w_ready  (fsm_w_ready),
        .fsm_ar_valid (fsm_ar_valid),
        .fsm_ar_ready (fsm_ar_ready),
        .b_valid      (b_valid),
        .b_ready      (b_ready),
        .r_valid      (r_valid),
        .r_ready      (r_ready)
    );

    adam_axil_apb_fsm u_fsm (
        .clk          (clk),
        .reset        (reset),
        .fsm_aw_valid (fsm_aw_valid),
        .aw_addr      (aw_addr),
        .aw_prot      (aw_prot),
        .fsm_w_valid  (fsm_w_valid),
        .w_data       (w_data),
        .w_strb       (w_strb),
        .fsm_ar_valid (fsm_ar_valid),
        .ar_addr      (ar_addr),
        .ar_prot      (ar_prot),
        .fsm_aw_ready (fsm_aw_ready),
        .fsm_w_ready  (fsm_w_ready),
        .fsm_ar_ready (fsm_ar_ready),
        .map_start    (map_start),
        .map_end      (map_end),
        .paddr        (paddr),
        .pprot        (pprot),
        .psel         (psel),
        .penable      (penable),
        .pwrite       (pwrite),
        .pwdata       (pwdata),
        .pstrb        (pstrb),
        .pready       (pready),
        .prdata       (prdata),
        .pslverr      (pslverr),
        .b_full       (b_full),
        .r_full       (r_full),
        .b_push       (b_push),
        .b_push_resp  (b_push_resp),
        .r_push       (r_push),
        .r_push_data  (r_push_data),
        .r_push_resp  (r_push_resp)
    );

    adam_axil_resp_buf u_resp_buf (
        .clk         (clk),
        .reset       (reset),
        .b_push      (b_push),
        .b_push_resp (b_push_resp),
        .b_full      (b_full),
        .r_push      (r_push),
        .r_push_data (r_push_data),
        .r_push_resp (r_push_resp),
        .r_full      (r_full),
        .b_valid     (b_valid),
        .b_resp      (b_resp),
        .b_ready     (b_ready),
        .r_valid     (r_valid),
        .r_data      (r_data),
        .r_resp      (r_resp),
        .r_ready     (r_ready)
    );

endmodule

// ==== adam_axil_apb_fsm.sv ====
`timescale 1ns/1ps

module adam_axil_apb_fsm import adam_bridge_pkg::*; (
    input  logic clk,
    input  logic reset,

    // Write request
    input  logic  fsm_aw_valid,
    input  addr_t aw_addr,
    input  prot_t aw_prot,
    input  logic  fsm_w_valid,
    input  data_t w_data,
    input  strb_t w_strb,

    // Read request
    input  logic  fsm_ar_valid,
    input  addr_t ar_addr,
    input  prot_t ar_prot,

    output logic fsm_aw_ready,
    output logic fsm_w_ready,
    output logic fsm_ar_ready,

    input  addr_t [NO_APBS-1:0] map_start,
    input  addr_t [NO_APBS-1:0] map_end,

    // APB master ports
    output addr_t [NO_APBS-1:0] paddr,
    output prot_t [NO_APBS-1:0] pprot,
    output logic  [NO_APBS-1:0] psel,
    output logic  [NO_APBS-1:0] penable,
    output logic  [NO_APBS-1:0] pwrite,
    output data_t [NO_APBS-1:0] pwdata,
    output strb_t [NO_APBS-1:0] pstrb,
    input  logic  [NO_APBS-1:0] pready,
    input  data_t [NO_APBS-1:0] prdata,
    input  logic  [NO_APBS-1:0] pslverr,

    // Response buffer
    input  logic  b_full,
    input  logic  r_full,
    output logic  b_push,
    output resp_t b_push_resp,
    output logic  r_push,
    output data_t r_push_data,
    output resp_t r_push_resp
);

    typedef enum logic [2:0] {
        IDLE,
        DECODE,
        SETUP,
        ACCESS,
        RESPOND
    } state_t;

    state_t    state;
    state_t    state_next;
    logic      last_write;
    logic      wr_req;
    logic      rd_req;
    logic      pick_write;
    logic      pick_read;
    logic      hit;
    port_idx_t hit_idx;
    logic      apb_active;
    logic      apb_done;
    logic      finish;
    resp_t     resp_now;

    logic      req_write;
    addr_t     req_addr;
    prot_t     req_prot;
    data_t     req_data;
    strb_t     req_strb;
    addr_t     req_offset;
    port_idx_t port_sel;

    assign wr_req = fsm_aw_valid && fsm_w_valid && !b_full;
    assign rd_req = fsm_ar_valid && !r_full;

    // Alternate when both directions wait
    assign pick_write = (state == IDLE) && wr_req && (!rd_req || !last_write);
    assign pick_read  = (state == IDLE) && rd_req && !pick_write;

    assign fsm_aw_ready = pick_write;
    assign fsm_w_ready  = pick_write;
    assign fsm_ar_ready = pick_read;

    // Lowest matching rule wins
    always_comb begin
        hit     = 1'b0;
        hit_idx = '0;
        for (int i = NO_APBS - 1; i >= 0; i--) begin
            if (req_addr >= map_start[i] && req_addr < map_end[i]) begin
                hit     = 1'b1;
                hit_idx = port_idx_t'(i);
            end
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            IDLE:    if (pick_write || pick_read) state_next = DECODE;
            DECODE:  state_next = hit ? SETUP : RESPOND; // Miss skips APB
            SETUP:   state_next = ACCESS;
            ACCESS:  if (pready[port_sel]) state_next = IDLE;
            RESPOND: state_next = IDLE;
            default: state_next = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= IDLE;
            last_write <= 1'b0;
        end else begin
            state <= state_next;
            if (pick_write || pick_read) begin
                last_write <= pick_write;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (pick_write) begin
            req_write <= 1'b1;
            req_addr  <= aw_addr;
            req_prot  <= aw_prot;
            req_data  <= w_data;
            req_strb  <= w_strb;
        end else if (pick_read) begin
            req_write <= 1'b0;
            req_addr  <= ar_addr;
            req_prot  <= ar_prot;
        end
        if (state == DECODE) begin
            port_sel   <= hit_idx;
            req_offset <= req_addr - map_start[hit_idx]; // Port sees local address
        end
    end

    assign apb_active = (state == SETUP) || (state == ACCESS);
    assign apb_done   = (state == ACCESS) && pready[port_sel];
    assign finish     = apb_done || (state == RESPOND);

    assign resp_now = (state == RESPOND) ? RESP_DECERR :
                      pslverr[port_sel]  ? RESP_SLVERR : RESP_OKAY;

    assign b_push      = finish && req_write;
    assign b_push_resp = resp_now;
    assign r_push      = finish && !req_write;
    assign r_push_resp = resp_now;
    assign r_push_data = apb_done ? prdata[port_sel] : '0;

    for (genvar i = 0; i < NO_APBS; i++) begin : g_apb
        assign psel[i]    = apb_active && (port_sel == port_idx_t'(i));
        assign penable[i] = psel[i] && (state == ACCESS);
        assign pwrite[i]  = psel[i] && req_write;
        assign paddr[i]   = psel[i] ? req_offset : '0;
        assign pprot[i]   = psel[i] ? req_prot : '0;
        assign pwdata[i]  = (psel[i] && req_write) ? req_data : '0;
        assign pstrb[i]   = (psel[i] && req_write) ? req_strb : '0;

        // Access phase only follows a setup cycle on the same port
        assert property (@(posedge clk) disable iff (reset)
            penable[i] |-> psel[i] && $past(psel[i]))
            else $error("penable without setup on APB port %0d", i);
    end

endmodule

// ==== adam_axil_pause.sv ====
`timescale 1ns/1ps

module adam_axil_pause import adam_bridge_pkg::*; (
    input  logic clk,
    input  logic reset,

    input  logic pause_req,
    output logic pause_ack,

    // Request side from the master
    input  logic aw_valid,
    output logic aw_ready,
    input  logic w_valid,
    output logic w_ready,
    input  logic ar_valid,
    output logic ar_ready,

    // Request side towards the FSM
    output logic fsm_aw_valid,
    input  logic fsm_aw_ready,
    output logic fsm_w_valid,
    input  logic fsm_w_ready,
    output logic fsm_ar_valid,
    input  logic fsm_ar_ready,

    // Response handshakes at the buffer output
    input  logic b_valid,
    input  logic b_ready,
    input  logic r_valid,
    input  logic r_ready
);

    trans_cnt_t count;
    logic       block;
    logic       req_fire;
    logic       b_fire;
    logic       r_fire;

    assign block = pause_req || (count == trans_cnt_t'(MAX_TRANS));

    // Hide requests from the FSM while blocked
    assign fsm_aw_valid = aw_valid && !block;
    assign fsm_w_valid  = w_valid && !block;
    assign fsm_ar_valid = ar_valid && !block;

    assign aw_ready = fsm_aw_ready && !block;
    assign w_ready  = fsm_w_ready && !block;
    assign ar_ready = fsm_ar_ready && !block;

    // AW and W are taken together, so AW alone marks a write
    assign req_fire = (aw_valid && aw_ready) || (ar_valid && ar_ready);
    assign b_fire   = b_valid && b_ready;
    assign r_fire   = r_valid && r_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            count <= '0;
        end else begin
            count <= count + trans_cnt_t'(req_fire)
                           - trans_cnt_t'(b_fire)
                           - trans_cnt_t'(r_fire);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pause_ack <= 1'b0;
        end else begin
            pause_ack <= pause_req && (count == '0); // Drops one cycle after pause_req
        end
    end

    // Ack must only be given while the bridge is drained
    assert property (@(posedge clk) disable iff (reset)
        pause_ack |-> (count == '0))
        else $error("pause_ack high with %0d outstanding transactions", count);

    assert property (@(posedge clk) disable iff (reset)
        count <= trans_cnt_t'(MAX_TRANS))
        else $error("outstanding count %0d above limit", count);

endmodule

// ==== adam_axil_resp_buf.sv ====
`timescale 1ns/1ps

module adam_axil_resp_buf import adam_bridge_pkg::*; (
    input  logic  clk,
    input  logic  reset,

    // Write response from the FSM
    input  logic  b_push,
    input  resp_t b_push_resp,
    output logic  b_full,

    // Read response from the FSM
    input  logic  r_push,
    input  data_t r_push_data,
    input  resp_t r_push_resp,
    output logic  r_full,

    // AXI-Lite B channel
    output logic  b_valid,
    output resp_t b_resp,
    input  logic  b_ready,

    // AXI-Lite R channel
    output logic  r_valid,
    output data_t r_data,
    output resp_t r_resp,
    input  logic  r_ready
);

    assign b_full = b_valid;
    assign r_full = r_valid;

    always_ff @(posedge clk) begin
        if (reset) begin
            b_valid <= 1'b0;
        end else if (b_push) begin
            b_valid <= 1'b1;
        end else if (b_ready) begin
            b_valid <= 1'b0; // Freed on handshake
        end
    end

    always_ff @(posedge clk) begin
        if (b_push) begin
            b_resp <= b_push_resp;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            r_valid <= 1'b0;
        end else if (r_push) begin
            r_valid <= 1'b1;
        end else if (r_ready) begin
            r_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (r_push) begin
            r_data <= r_push_data;
            r_resp <= r_push_resp;
        end
    end

    // FSM must only start an access whose entry is free
    assert property (@(posedge clk) disable iff (reset) b_push |-> !b_full)
        else $error("B response pushed into full entry");

    assert property (@(posedge clk) disable iff (reset) r_push |-> !r_full)
        else $error("R response pushed into full entry");

endmodule

// ==== adam_bridge_pkg.sv ====
package adam_bridge_pkg;

    // Bus widths
    localparam int ADDR_WIDTH = 32;
    localparam int DATA_WIDTH = 32;
    localparam int STRB_WIDTH = DATA_WIDTH / 8; // One strobe per byte
    localparam int PROT_WIDTH = 3;
    localparam int RESP_WIDTH = 2;

    // APB ports, one address rule each
    localparam int NO_APBS = 2;

    localparam int MAX_TRANS = 2; // Outstanding limit seen by the pause gate

    typedef logic [ADDR_WIDTH-1:0] addr_t;
    typedef logic [DATA_WIDTH-1:0] data_t;
    typedef logic [STRB_WIDTH-1:0] strb_t;
    typedef logic [PROT_WIDTH-1:0] prot_t;
    typedef logic [RESP_WIDTH-1:0] resp_t;

    typedef logic [$clog2(NO_APBS)-1:0] port_idx_t; // Selected APB port

    typedef logic [$clog2(MAX_TRANS+1)-1:0] trans_cnt_t; // Holds 0 up to MAX_TRANS

    // AXI response codes
    localparam resp_t RESP_OKAY   = 2'd0;
    localparam resp_t RESP_SLVERR = 2'd2;
    localparam resp_t RESP_DECERR = 2'd3;

endpackage

// ==== files.f ====
adam_bridge_pkg.sv
adam_axil_pause.sv
adam_axil_apb_fsm.sv
adam_axil_resp_buf.sv
adam_axil_apb_bridge.sv
tb_apb_mem.sv
tb_adam_axil_apb_bridge.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the bridge testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_adam_axil_apb_bridge -f files.f -o tb_sim

./obj_dir/tb_sim | tee sim.log

if grep -q "Simulation completed successfully" sim.log; then
    exit 0
fi
exit 1

// ==== tb_adam_axil_apb_bridge.sv ====
`timescale 1ns/1ps

module tb_adam_axil_apb_bridge import adam_bridge_pkg::*; ();

    typedef enum logic [2:0] {OP_WRITE, OP_READ, OP_PEEK, OP_PAUSE, OP_BPRESS} op_t;

    typedef struct packed {
        op_t   op;
        addr_t addr;
        data_t wdata;
        strb_t strb;
        data_t exp_data;
        resp_t exp_resp;
    } row_t;

    logic  clk;
    logic  reset;
    logic  pause_req;
    logic  pause_ack;
    addr_t aw_addr;
    prot_t aw_prot;
    logic  aw_valid;
    logic  aw_ready;
    data_t w_data;
    strb_t w_strb;
    logic  w_valid;
    logic  w_ready;
    resp_t b_resp;
    logic  b_valid;
    logic  b_ready;
    addr_t ar_addr;
    prot_t ar_prot;
    logic  ar_valid;
    logic  ar_ready;
    data_t r_data;
    resp_t r_resp;
    logic  r_valid;
    logic  r_ready;

    addr_t [NO_APBS-1:0] paddr;
    prot_t [NO_APBS-1:0] pprot;
    logic  [NO_APBS-1:0] psel;
    logic  [NO_APBS-1:0] penable;
    logic  [NO_APBS-1:0] pwrite;
    data_t [NO_APBS-1:0] pwdata;
    strb_t [NO_APBS-1:0] pstrb;
    logic  [NO_APBS-1:0] pready;
    data_t [NO_APBS-1:0] prdata;
    logic  [NO_APBS-1:0] pslverr;
    addr_t [NO_APBS-1:0] map_start;
    addr_t [NO_APBS-1:0] map_end;

    logic [31:0] lfsr_state;
    logic [1:0]  wait_next;
    prot_t       apb_prot; // Prot of the last accepted request
    row_t        rows[$];
    logic        rows_loaded;
    int          errors;
    int          checks;

    adam_axil_apb_bridge uut (.*);

    tb_apb_mem #(.ID(0)) mem_0 (
        .clk(clk), .reset(reset), .psel(psel[0]), .penable(penable[0]),
        .pwrite(pwrite[0]), .paddr(paddr[0]), .pwdata(pwdata[0]), .pstrb(pstrb[0]),
        .wait_states(wait_next), .pready(pready[0]), .prdata(prdata[0]),
        .pslverr(pslverr[0])
    );

    tb_apb_mem #(.ID(1)) mem_1 (
        .clk(clk), .reset(reset), .psel(psel[1]), .penable(penable[1]),
        .pwrite(pwrite[1]), .paddr(paddr[1]), .pwdata(pwdata[1]), .pstrb(pstrb[1]),
        .wait_states(wait_next), .pready(pready[1]), .prdata(prdata[1]),
        .pslverr(pslverr[1])
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // New wait count after each finished APB transfer
    always @(posedge clk) begin
        logic [31:0] s;
        logic [1:0]  w;
        if (reset || |(psel & penable & pready)) begin
            s = reset ? 32'h3924_812d : lfsr_state;
            for (int b = 0; b < 2; b++) begin
                w[b] = s[0];
                s = lfsr_next(s);
            end
            lfsr_state <= s;
            wait_next  <= w;
        end
    end

    task automatic check_data(input string name, input data_t got, input data_t exp);
        checks = checks + 1;
        if (got !== exp) begin
            errors = errors + 1;
            $display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_resp(input string name, input resp_t got, input resp_t exp);
        checks = checks + 1;
        if (got !== exp) begin
            errors = errors + 1;
            $display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_prot(input string name, input prot_t got, input prot_t exp);
        checks = checks + 1;
        if (got !== exp) begin
            errors = errors + 1;
            $display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_level(input string name, input logic got, input logic exp);
        checks = checks + 1;
        if (got !== exp) begin
            errors = errors + 1;
            $display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    // pprot carries the prot of the request in flight
    always @(negedge clk) begin
        for (int i = 0; i < NO_APBS; i++) begin
            if (psel[i] === 1'b1) begin
                check_prot($sformatf("pprot[%0d]", i), pprot[i], apb_prot);
            end
        end
    end

    // Backdoor read of the memory behind a global address
    function automatic data_t peek_word(input addr_t addr);
        addr_t local_addr;
        if (addr >= map_start[0] && addr < map_end[0]) begin
            local_addr = addr - map_start[0];
            return mem_0.mem[local_addr[7:2]];
        end
        if (addr >= map_start[1] && addr < map_end[1]) begin
            local_addr = addr - map_start[1];
            return mem_1.mem[local_addr[7:2]];
        end
        return 'x;
    endfunction

    task automatic send_write(input addr_t addr, input data_t data, input strb_t strb);
        logic done;
        @(posedge clk);
        aw_addr  <= addr;
        aw_prot  <= 3'b010; // Unprivileged non-secure data
        aw_valid <= 1'b1;
        w_data   <= data;
        w_strb   <= strb;
        w_valid  <= 1'b1;
        done = 1'b0;
        while (!done) begin
            @(negedge clk);
            done = aw_ready && w_ready;
            @(posedge clk);
        end
        aw_valid <= 1'b0;
        w_valid  <= 1'b0;
        apb_prot = 3'b010;
    endtask

    task automatic wait_ar_accept();
        logic done;
        done = 1'b0;
        while (!done) begin
            @(negedge clk);
            done = ar_ready;
            @(posedge clk);
        end
        ar_valid <= 1'b0;
        apb_prot = 3'b101;
    endtask

    task automatic send_read(input addr_t addr);
        @(posedge clk);
        ar_addr  <= addr;
        ar_prot  <= 3'b101; // Privileged secure instruction
        ar_valid <= 1'b1;
        wait_ar_accept();
    endtask

    task automatic wait_b(output resp_t resp);
        logic done;
        done = 1'b0;
        while (!done) begin
            @(negedge clk);
            done = b_valid && b_ready;
            resp = b_resp;
            @(posedge clk);
        end
    endtask

    task automatic wait_r(output data_t data, output resp_t resp);
        logic done;
        done = 1'b0;
        while (!done) begin
            @(negedge clk);
            done = r_valid && r_ready;
            data = r_data;
            resp = r_resp;
            @(posedge clk);
        end
    endtask

    task automatic check_read(input row_t row, input data_t data, input resp_t resp);
        check_resp("r_resp", resp, row.exp_resp);
        if (row.exp_resp == RESP_OKAY) begin
            check_data("r_data", data, row.exp_data);
        end
    endtask

    task automatic run_pause(input row_t row);
        data_t data;
        resp_t resp;
        @(posedge clk);
        pause_req <= 1'b1;
        @(negedge clk);
        check_level("pause_ack", pause_ack, 1'b0);
        @(negedge clk);
        check_level("pause_ack", pause_ack, 1'b1); // One cycle after the request
        @(posedge clk);
        ar_addr  <= row.addr;
        ar_prot  <= 3'b101;
        ar_valid <= 1'b1;
        repeat (20) begin
            @(negedge clk);
            check_level("ar_ready", ar_ready, 1'b0);
            @(posedge clk);
        end
        pause_req <= 1'b0;
        wait_ar_accept();
        wait_r(data, resp);
        check_read(row, data, resp);
        @(negedge clk);
        check_level("pause_ack", pause_ack, 1'b0);
    endtask

    task automatic run_backpressure(input row_t row);
        data_t data;
        resp_t resp;
        @(posedge clk);
        b_ready <= 1'b0;
        send_write(row.addr, row.wdata, row.strb);
        send_read(row.addr);
        wait_r(data, resp);
        check_resp("r_resp", resp, RESP_OKAY);
        check_data("r_data", data, row.exp_data);
        @(negedge clk);
        check_level("b_valid", b_valid, 1'b1); // B still parked
        @(posedge clk);
        b_ready <= 1'b1;
        wait_b(resp);
        check_resp("b_resp", resp, row.exp_resp);
    endtask

    task automatic apply_row(input row_t row);
        data_t data;
        resp_t resp;
        case (row.op)
            OP_WRITE: begin
                send_write(row.addr, row.wdata, row.strb);
                wait_b(resp);
                check_resp("b_resp", resp, row.exp_resp);
            end
            OP_READ: begin
                send_read(row.addr);
                wait_r(data, resp);
                check_read(row, data, resp);
            end
            OP_PEEK:   check_data("mem word", peek_word(row.addr), row.exp_data);
            OP_PAUSE:  run_pause(row);
            OP_BPRESS: run_backpressure(row);
            default: begin
                errors = errors + 1;
                $display("Unknown operation in stimulus row");
            end
        endcase
    endtask

    task automatic add_row(input op_t op, input addr_t addr, input data_t wdata,
                           input strb_t strb, input data_t exp_data, input resp_t exp_resp);
        row_t row;
        row.op       = op;
        row.addr     = addr;
        row.wdata    = wdata;
        row.strb     = strb;
        row.exp_data = exp_data;
        row.exp_resp = exp_resp;
        rows.push_back(row);
    endtask

    // Fill value of an untouched word is C0DE_0000 | port << 8 | word
    task automatic load_table();
        add_row(OP_WRITE,  32'h1000_0008, 32'h1111_2222, 4'hF, 32'h0, RESP_OKAY);
        add_row(OP_READ,   32'h1000_0008, 32'h0, 4'h0, 32'h1111_2222, RESP_OKAY);
        add_row(OP_WRITE,  32'h2000_0008, 32'h3333_4444, 4'hF, 32'h0, RESP_OKAY);
        add_row(OP_READ,   32'h2000_0008, 32'h0, 4'h0, 32'h3333_4444, RESP_OKAY);
        add_row(OP_READ,   32'h1000_0008, 32'h0, 4'h0, 32'h1111_2222, RESP_OKAY);
        add_row(OP_PEEK,   32'h1000_0008, 32'h0, 4'h0, 32'h1111_2222, RESP_OKAY);
        add_row(OP_PEEK,   32'h2000_0008, 32'h0, 4'h0, 32'h3333_4444, RESP_OKAY);
        add_row(OP_READ,   32'h2000_000C, 32'h0, 4'h0, 32'hC0DE_0103, RESP_OKAY);
        add_row(OP_WRITE,  32'h1000_0008, 32'hAABB_CCDD, 4'b0101, 32'h0, RESP_OKAY);
        add_row(OP_READ,   32'h1000_0008, 32'h0, 4'h0, 32'h11BB_22DD, RESP_OKAY);
        add_row(OP_WRITE,  32'h3000_0010, 32'hDEAD_BEEF, 4'hF, 32'h0, RESP_DECERR);
        add_row(OP_WRITE,  32'h1000_1000, 32'hDEAD_BEEF, 4'hF, 32'h0, RESP_DECERR);
        add_row(OP_READ,   32'h0FFF_FFFC, 32'h0, 4'h0, 32'h0, RESP_DECERR);
        add_row(OP_READ,   32'h1000_0010, 32'h0, 4'h0, 32'hC0DE_0004, RESP_OKAY);
        add_row(OP_READ,   32'h2000_0010, 32'h0, 4'h0, 32'hC0DE_0104, RESP_OKAY);
        add_row(OP_WRITE,  32'h1000_0100, 32'h0BAD_0BAD, 4'hF, 32'h0, RESP_SLVERR);
        add_row(OP_READ,   32'h2000_0FFC, 32'h0, 4'h0, 32'h0, RESP_SLVERR);
        add_row(OP_READ,   32'h1000_00FC, 32'h0, 4'h0, 32'hC0DE_003F, RESP_OKAY);
        add_row(OP_PAUSE,  32'h2000_0008, 32'h0, 4'h0, 32'h3333_4444, RESP_OKAY);
        add_row(OP_BPRESS, 32'h2000_0020, 32'h5555_6666, 4'hF, 32'h5555_6666, RESP_OKAY);
        add_row(OP_READ,   32'h2000_0020, 32'h0, 4'h0, 32'h5555_6666, RESP_OKAY);
    endtask

    initial begin
        int limit;
        wait (rows_loaded);
        limit = rows.size() * 50 + 10; // Plus the reset cycles
        repeat (limit) @(posedge clk);
        $display("Run timed out after %0d cycles before the table was done", limit);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        rows_loaded = 1'b0;
        errors      = 0;
        checks      = 0;
        apb_prot    = '0;
        reset       = 1'b1;
        pause_req   = 1'b0;
        aw_addr     = '0;
        aw_prot     = '0;
        aw_valid    = 1'b0;
        w_data      = '0;
        w_strb      = '0;
        w_valid     = 1'b0;
        b_ready     = 1'b1;
        ar_addr     = '0;
        ar_prot     = '0;
        ar_valid    = 1'b0;
        r_ready     = 1'b1;
        map_start[0] = 32'h1000_0000; // 4 KiB window per port
        map_end[0]   = 32'h1000_1000;
        map_start[1] = 32'h2000_0000;
        map_end[1]   = 32'h2000_1000;
        load_table();
        rows_loaded = 1'b1;
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        foreach (rows[i]) begin
            apply_row(rows[i]);
        end
        repeat (5) @(posedge clk);
        $display("Errors: %0d in %0d checks", errors, checks);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== tb_apb_mem.sv ====
`timescale 1ns/1ps

module tb_apb_mem import adam_bridge_pkg::*; #(
    parameter int ID = 0 // Tags the fill pattern per port
) (
    input  logic       clk,
    input  logic       reset,
    input  logic       psel,
    input  logic       penable,
    input  logic       pwrite,
    input  addr_t      paddr,
    input  data_t      pwdata,
    input  strb_t      pstrb,
    input  logic [1:0] wait_states, // Wait count for the next transfer
    output logic       pready,
    output data_t      prdata,
    output logic       pslverr
);

    data_t      mem [64];
    logic [1:0] wait_left;
    logic       in_range;
    logic [5:0] word;

    assign in_range = paddr < addr_t'(64 * 4);
    assign word     = paddr[7:2];
    assign pready   = psel && penable && (wait_left == 2'd0);
    assign pslverr  = pready && !in_range; // Words 64 and up are not backed
    assign prdata   = (pready && in_range && !pwrite) ? mem[word] : '0;

    always_ff @(posedge clk) begin
        if (reset) begin
            wait_left <= 2'd0;
            for (int i = 0; i < 64; i++) begin
                mem[i] <= data_t'(32'hC0DE_0000 | (ID << 8) | i); // Word index in low bits
            end
        end else begin
            if (psel && !penable) begin
                wait_left <= wait_states; // Setup cycle
            end else if (psel && penable && wait_left != 2'd0) begin
                wait_left <= wait_left - 2'd1;
            end
            if (pready && pwrite && in_range) begin
                for (int b = 0; b < STRB_WIDTH; b++) begin
                    if (pstrb[b]) begin
                        mem[word][8*b +: 8] <= pwdata[8*b +: 8];
                    end
                end
            end
        end
    end

endmodule
